//--- Makefile
# Verilator simulation of the micro-op expander

TOP = microOpExpanderTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+hw
+incdir+verification
hw/armInstrPkg.sv
hw/microOpPkg.sv
hw/instrClassifier.sv
hw/regListWalker.sv
hw/microOpSequencer.sv
hw/microOpBuilder.sv
hw/microOpExpander.sv
verification/microOpExpanderTb.sv

//--- hw/armInstrPkg.sv
`include "microOp_consts.svh"

package armInstrPkg;

	// Raw instruction word as it leaves fetch
	typedef logic [`INSTR_WIDTH-1:0] instrWord;

	// Register number in any Rn/Rd/Rm field
	typedef logic [3:0] regIndex;

	// One bit per register in an LDM/STM list
	typedef logic [`REG_COUNT-1:0] regList;

	// Decode result of the classifier
	typedef enum logic [1:0] {
		classPlain,           // Goes through untouched
		classRsr,             // Register-shifted-register data processing
		classBranchLink,      // BL
		classBlockTransfer    // LDM/STM with a nonzero list
	} instrClass;

	// Data-processing opcodes the expander emits
	typedef enum logic [3:0] {
		opSub = 4'd2,   // Rd = Rn - op2
		opAdd = 4'd4,   // Rd = Rn + op2
		opMov = 4'd13   // Rd = op2
	} dpOpcode;

endpackage

//--- hw/instrClassifier.sv
`include "microOp_consts.svh"

module instrClassifier
	import armInstrPkg::*;
(
	input instrWord instr,
	output instrClass cls
);

	logic isDpRegister;   // Bits 27:25 all zero
	logic isRegShift;     // Bit 7 low, bit 4 high means shift amount in Rs
	logic isBx;           // BX shares the RSR bit pattern
	logic isRsr;
	logic isBl;
	logic isBlock;
	logic listNonEmpty;

	always_comb begin
		isDpRegister = (instr[27:25] == 3'b000);
		isRegShift = ~instr[7] & instr[4];
		isBx = (instr[27:6] == `BX_PATTERN);
		isRsr = isDpRegister & isRegShift & ~isBx;
	end

	always_comb begin
		isBl = (instr[27:24] == `BL_PATTERN);
		listNonEmpty = |instr[15:0];   // Empty list is left to the datapath
		isBlock = (instr[27:25] == `BLOCK_PATTERN) & listNonEmpty;
	end

	// Priority order matters only for documentation, the patterns are disjoint
	always_comb begin
		if (isRsr) begin
			cls = classRsr;
		end else if (isBl) begin
			cls = classBranchLink;
		end else if (isBlock) begin
			cls = classBlockTransfer;
		end else begin
			cls = classPlain;   // Everything else passes through
		end
	end

endmodule

//--- hw/microOpBuilder.sv
`include "microOp_consts.svh"

module microOpBuilder
	import armInstrPkg::*;
	import microOpPkg::*;
(
	input instrWord instr,
	input uopKind kind,
	input regIndex nextReg,
	input popCount fullCount,
	input logic [`OFFSET_WIDTH-1:0] startOffset,
	input logic addUp,
	output instrWord uOpInstr
);

	logic [3:0] cond;     // Condition field copied into every micro-op
	regIndex baseReg;     // Rn of the original instruction
	logic loadBit;        // L bit of LDM/STM
	dpOpcode wbOp;        // Base update direction

	assign cond = instr[31:28];
	assign baseReg = instr[19:16];
	assign loadBit = instr[20];
	assign wbOp = instr[23] ? opAdd : opSub;   // U bit of the block transfer

	always_comb begin
		case (kind)
			ukRsrShift: begin
				uOpInstr = {cond, instr[27:25],
					opMov, 1'b0,              // MOV, no flag update
					4'b0000, `RZ_REG,         // Rn unused, result to Rz
					instr[11:0]};             // Keep shift by Rs
			end
			ukRsrOp: begin
				uOpInstr = {instr[31:12],
					8'b0, `RZ_REG};           // No shift, Rm = Rz
			end
			ukLinkSave: begin
				uOpInstr = {cond, `DP_IMM_CLASS,
					opSub, 1'b0,
					`PC_REG, `LINK_REG,       // LR = PC - 4
					4'b0000, 8'(`WORD_BYTES)};
			end
			ukBranch: begin
				uOpInstr = {instr[31:25], 1'b0, instr[23:0]};   // Clear L bit
			end
			ukFirstTransfer: begin
				uOpInstr = {cond, `SINGLE_IMM_CLASS,
					1'b1,                     // Pre-indexed
					addUp,
					1'b0,                     // Word access
					1'b0,                     // No base update
					loadBit,
					baseReg,
					nextReg,
					startOffset};
			end
			ukNextTransfer: begin
				uOpInstr = {cond, `SINGLE_IMM_CLASS,
					1'b1, 1'b1,               // Pre-indexed, add
					1'b0, 1'b0,
					loadBit,
					`RZ_REG,                  // Address chain runs through Rz
					nextReg,
					8'b0, `RZ_REG};           // Offset field 15 marks the Rz step
			end
			ukBaseWriteback: begin
				uOpInstr = {cond, `DP_IMM_CLASS,
					wbOp, 1'b0,
					baseReg, baseReg,         // Rn = Rn +/- imm
					`WB_ROTATE,
					3'b000, fullCount};       // Count ror 30 is count * 4
			end
			default: begin
				uOpInstr = instr;             // Plain instruction
			end
		endcase
	end

endmodule

//--- hw/microOpExpander.sv
`include "microOp_consts.svh"

module microOpExpander
	import armInstrPkg::*;
	import microOpPkg::*;
(
	input logic clk,
	input logic reset,
	input instrWord instr,
	input logic stallIn,
	output instrWord uOpInstr,
	output logic instrMux,
	output logic noFlagUpdate,
	output logic uOpStall,
	output logic ldmStmForward,
	output logic prevRsr,
	output rzControl regFileRz
);

	instrClass cls;
	uopKind kind;
	regIndex nextReg;
	popCount remainingAfter;
	popCount fullCount;
	logic [`OFFSET_WIDTH-1:0] startOffset;
	logic addUp;

	instrClassifier classifier (.instr(instr), .cls(cls));

	microOpSequencer sequencer (.clk(clk), .reset(reset), .stallIn(stallIn), .instr(instr),
		.cls(cls), .remainingAfter(remainingAfter), .state(), .kind(kind),
		.uOpStall(uOpStall), .noFlagUpdate(noFlagUpdate), .ldmStmForward(ldmStmForward),
		.prevRsr(prevRsr), .instrMux(instrMux), .regFileRz(regFileRz));

	regListWalker walker (.clk(clk), .reset(reset), .stallIn(stallIn), .instr(instr),
		.kind(kind), .nextReg(nextReg), .remainingAfter(remainingAfter),
		.fullCount(fullCount), .startOffset(startOffset), .addUp(addUp));

	microOpBuilder builder (.instr(instr), .kind(kind), .nextReg(nextReg),
		.fullCount(fullCount), .startOffset(startOffset), .addUp(addUp),
		.uOpInstr(uOpInstr));

endmodule

//--- hw/microOpPkg.sv
package microOpPkg;

	// Sequencer state, one per multi-cycle flavour
	typedef enum logic [2:0] {
		stReady,        // Waiting for a new instruction
		stRsr,          // Second half of RSR
		stBranchLink,   // Branch after link save
		stLoadMulti,    // Remaining LDM transfers
		stStoreMulti,   // Remaining STM transfers
		stWriteback     // Base update of LDM/STM
	} seqState;

	// Which micro-op the builder should assemble this cycle
	typedef enum logic [2:0] {
		ukPass,            // Original instruction
		ukRsrShift,        // MOV Rz, Rm shifted by Rs
		ukRsrOp,           // Original op with Rz as operand 2
		ukLinkSave,        // SUB LR, PC, #4
		ukBranch,          // Plain B
		ukFirstTransfer,   // Single transfer from base Rn
		ukNextTransfer,    // Single transfer from Rz + 4
		ukBaseWriteback    // Rn = Rn +/- count * 4
	} uopKind;

	// {initial RA1 mux, Rz on WA3, Rz on RA2, Rz on RA1}
	typedef logic [3:0] rzControl;

	// Register count of a list, 0..16
	typedef logic [4:0] popCount;

endpackage

//--- hw/microOpSequencer.sv
module microOpSequencer
	import armInstrPkg::*;
	import microOpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic stallIn,
	input instrWord instr,
	input instrClass cls,
	input popCount remainingAfter,
	output seqState state,
	output uopKind kind,
	output logic uOpStall,
	output logic noFlagUpdate,
	output logic ldmStmForward,
	output logic prevRsr,
	output logic instrMux,
	output rzControl regFileRz
);

	seqState nextState;
	logic writeBack;    // W bit of LDM/STM
	logic moreRegs;     // Another transfer follows this one
	logic seqTail;      // Micro-ops still follow a transfer

	assign writeBack = instr[21];
	assign moreRegs = (remainingAfter != '0);
	assign seqTail = moreRegs | writeBack;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stReady;
		end else if (!stallIn) begin
			state <= nextState;   // Stall freezes the sequence
		end
	end

	// Kind depends on state and class only, never on the walker
	always_comb begin
		case (state)
			stReady: begin
				case (cls)
					classRsr: kind = ukRsrShift;
					classBranchLink: kind = ukLinkSave;
					classBlockTransfer: kind = ukFirstTransfer;
					default: kind = ukPass;
				endcase
			end
			stRsr: kind = ukRsrOp;
			stBranchLink: kind = ukBranch;
			stLoadMulti, stStoreMulti: kind = ukNextTransfer;
			stWriteback: kind = ukBaseWriteback;
			default: kind = ukPass;
		endcase
	end

	assign instrMux = (kind != ukPass);   // Any substitution selects the micro-op

	always_comb begin
		nextState = stReady;
		uOpStall = 1'b0;
		noFlagUpdate = 1'b0;
		ldmStmForward = 1'b0;
		prevRsr = 1'b0;
		regFileRz = 4'b0000;
		case (kind)
			ukRsrShift: begin
				nextState = stRsr;
				uOpStall = 1'b1;
				noFlagUpdate = 1'b1;
				regFileRz = 4'b1100;   // RA1 mux plus write to Rz
			end
			ukRsrOp: begin
				prevRsr = 1'b1;
				regFileRz = 4'b0010;   // Operand 2 read from Rz
			end
			ukLinkSave: begin
				nextState = stBranchLink;
				uOpStall = 1'b1;
			end
			ukFirstTransfer: begin
				noFlagUpdate = 1'b1;
				uOpStall = seqTail;
				if (moreRegs) begin
					nextState = instr[20] ? stLoadMulti : stStoreMulti;
				end else if (writeBack) begin
					nextState = stWriteback;
				end
			end
			ukNextTransfer: begin
				ldmStmForward = 1'b1;
				uOpStall = seqTail;
				regFileRz = (state == stLoadMulti) ? 4'b0001 : 4'b0000;
				if (moreRegs) begin
					nextState = state;   // Stay in LDM or STM
				end else if (writeBack) begin
					nextState = stWriteback;
				end
			end
			default: begin
				nextState = stReady;   // Pass, branch and writeback end here
			end
		endcase
	end

endmodule

//--- hw/microOp_consts.svh
`ifndef MICRO_OP_CONSTS_SVH
`define MICRO_OP_CONSTS_SVH

// Instruction word and register file geometry
`define INSTR_WIDTH 32            // Full ARM instruction word
`define REG_COUNT 16              // Architectural registers R0..R15

// Register numbers that the expander writes into micro-ops
`define PC_REG 4'd15              // Program counter
`define LINK_REG 4'd14            // Link register for BL
`define RZ_REG 4'd15              // Field value that steers a port to scratch Rz

// Address arithmetic of block transfers
`define WORD_BYTES 4              // Bytes per transferred register
`define OFFSET_WIDTH 12           // Immediate offset of a single load/store

// Rotate right by 30 turns a register count into a byte count
`define WB_ROTATE 4'd15

// Data-processing field values
`define DP_IMM_CLASS 3'b001       // Bits 27:25 for immediate data processing
`define SINGLE_IMM_CLASS 3'b010   // Bits 27:25 for single transfer, immediate offset

// Instruction field values used for matching
`define BL_PATTERN 4'b1011        // Bits 27:24 of branch-with-link
`define BLOCK_PATTERN 3'b100      // Bits 27:25 of LDM/STM
`define BX_PATTERN {8'b0001_0010, 12'hFFF, 2'b00}  // Bits 27:6 of BX, excluded from RSR

`endif

//--- hw/regListWalker.sv
`include "microOp_consts.svh"

module regListWalker
	import armInstrPkg::*;
	import microOpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic stallIn,
	input instrWord instr,
	input uopKind kind,
	output regIndex nextReg,
	output popCount remainingAfter,
	output popCount fullCount,
	output logic [`OFFSET_WIDTH-1:0] startOffset,
	output logic addUp
);

	regList heldList;    // Registers still to be transferred
	regList srcList;     // List this cycle picks from
	regList listAfter;   // List once nextReg is taken out
	logic [`OFFSET_WIDTH-1:0] listBytes;

	// First transfer starts from the instruction, later ones from the register
	assign srcList = (kind == ukFirstTransfer) ? regList'(instr[15:0]) : heldList;

	// Lowest set bit wins, so transfers run in ascending order
	always_comb begin
		nextReg = '0;
		for (int i = `REG_COUNT - 1; i >= 0; i--) begin
			if (srcList[i]) begin
				nextReg = regIndex'(i);
			end
		end
	end

	assign listAfter = srcList & (srcList - regList'(1));   // Clear lowest set bit
	assign remainingAfter = popCount'($countones(listAfter));
	assign fullCount = popCount'($countones(instr[15:0]));

	always_ff @(posedge clk) begin
		if (reset) begin
			heldList <= '0;
		end else if (!stallIn) begin
			heldList <= listAfter;   // Held while the pipe is stalled
		end
	end

	assign listBytes = `OFFSET_WIDTH'(fullCount * `WORD_BYTES);

	// Start address relative to Rn by addressing mode in bits 24:23
	always_comb begin
		case (instr[24:23])
			2'b00: begin   // DA, Rn - 4n + 4
				startOffset = listBytes - `OFFSET_WIDTH'(`WORD_BYTES);
				addUp = 1'b0;
			end
			2'b01: begin   // IA, Rn
				startOffset = '0;
				addUp = 1'b1;
			end
			2'b10: begin   // DB, Rn - 4n
				startOffset = listBytes;
				addUp = 1'b0;
			end
			default: begin   // IB, Rn + 4
				startOffset = `OFFSET_WIDTH'(`WORD_BYTES);
				addUp = 1'b1;
			end
		endcase
	end

endmodule

//--- verification/microOpRefModel.svh
`ifndef MICRO_OP_REF_MODEL_SVH
`define MICRO_OP_REF_MODEL_SVH

// Expected DUT outputs for one micro-op
typedef struct packed {
	instrWord word;
	logic mux;
	logic stall;
	logic noFlag;
	logic forward;
	logic prevRsr;
	rzControl rz;
} expectedUop;

typedef expectedUop uopList[$];

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

function automatic expectedUop makeUop(input instrWord word, input logic mux,
	input logic stall, input logic noFlag, input logic forward, input logic prevRsr,
	input rzControl rz);
	expectedUop u;
	u.word = word;
	u.mux = mux;
	u.stall = stall;
	u.noFlag = noFlag;
	u.forward = forward;
	u.prevRsr = prevRsr;
	u.rz = rz;
	return u;
endfunction

// Expected micro-op sequence of one instruction
function automatic uopList expandInstr(input instrWord i);
	uopList q;
	regIndex regs[$];
	logic [3:0] c;
	logic isBxFamily;
	logic [11:0] off;
	logic up;
	dpOpcode wbOp;
	int n;
	c = i[31:28];
	isBxFamily = (i[27:6] == 22'b0001_0010_1111_1111_1111_00);   // BX and BLX by register
	if (i[27:25] == 3'b000 && !i[7] && i[4] && !isBxFamily) begin
		q.push_back(makeUop({c, i[27:25], opMov, 1'b0, 4'd0, `RZ_REG, i[11:0]},
			1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 4'b1100));
		q.push_back(makeUop({i[31:12], 12'd15}, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 4'b0010));
	end else if (i[27:24] == 4'b1011) begin
		q.push_back(makeUop({c, 3'b001, opSub, 1'b0, `PC_REG, `LINK_REG, 12'd4},
			1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4'b0000));   // SUB LR, PC, #4
		q.push_back(makeUop({i[31:25], 1'b0, i[23:0]}, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000));
	end else if (i[27:25] == 3'b100 && i[15:0] != 16'd0) begin
		for (int r = 0; r < `REG_COUNT; r++) begin
			if (i[r]) begin
				regs.push_back(regIndex'(r));   // Ascending register order
			end
		end
		n = regs.size();
		case (i[24:23])
			2'b00: begin
				off = 12'((n - 1) * `WORD_BYTES);
				up = 1'b0;
			end
			2'b01: begin
				off = 12'd0;
				up = 1'b1;
			end
			2'b10: begin
				off = 12'(n * `WORD_BYTES);
				up = 1'b0;
			end
			default: begin
				off = 12'd4;
				up = 1'b1;
			end
		endcase
		q.push_back(makeUop({c, 3'b010, 1'b1, up, 2'b00, i[20], i[19:16], regs[0], off},
			1'b1, (n > 1) || i[21], 1'b1, 1'b0, 1'b0, 4'b0000));
		for (int k = 1; k < n; k++) begin
			q.push_back(makeUop({c, 3'b010, 2'b11, 2'b00, i[20], `RZ_REG, regs[k], 12'd15},
				1'b1, (k < n - 1) || i[21], 1'b0, 1'b1, 1'b0, {3'b000, i[20]}));
		end
		wbOp = i[23] ? opAdd : opSub;   // Base moves the way of the U bit
		if (i[21]) begin
			q.push_back(makeUop({c, 3'b001, wbOp, 1'b0, i[19:16], i[19:16], `WB_ROTATE,
				3'b000, 5'(n)}, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000));
		end
	end else begin
		q.push_back(makeUop(i, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000));   // Pass-through
	end
	return q;
endfunction

`endif

//--- verification/microOpExpanderTb.sv
`include "microOp_consts.svh"

module microOpExpanderTb
	import armInstrPkg::*;
	import microOpPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	`include "microOpRefModel.svh"

	logic clk;
	logic reset;
	instrWord instr;
	logic stallIn;
	instrWord uOpInstr;
	logic instrMux;
	logic noFlagUpdate;
	logic uOpStall;
	logic ldmStmForward;
	logic prevRsr;
	rzControl regFileRz;

	logic [31:0] lfsrState = 32'hdef39551;
	expectedUop expectQ[$];   // Micro-ops still owed by the DUT

	microOpExpander uut (.clk(clk), .reset(reset), .instr(instr), .stallIn(stallIn),
		.uOpInstr(uOpInstr), .instrMux(instrMux), .noFlagUpdate(noFlagUpdate),
		.uOpStall(uOpStall), .ldmStmForward(ldmStmForward), .prevRsr(prevRsr),
		.regFileRz(regFileRz));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	task automatic abortRun();
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string name, input instrWord got, input instrWord exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkRz(input string name, input rzControl got, input rzControl exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
			abortRun();
		end
	endtask

	// One LFSR step per bit taken
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < count; k++) begin
			lfsrState = lfsrStep(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic logic drawStall();
		logic [31:0] r;
		r = randBits(3);
		return &r[2:0];   // Stall on one edge in eight
	endfunction

	function automatic instrWord randomInstr(input logic [1:0] pick);
		instrWord w;
		logic [1:0] listShape;
		w = randBits(32);
		case (pick)
			2'd0: w[27:25] = 3'b001;   // Immediate data processing
			2'd1: begin
				w[27:25] = 3'b000;   // RSR
				w[7] = 1'b0;
				w[4] = 1'b1;
			end
			2'd2: w[27:24] = 4'b1011;   // BL
			default: begin
				w[27:25] = 3'b100;   // LDM/STM in any mode and W setting
				listShape = 2'(randBits(2));
				if (listShape == 2'd0) begin
					w[15:0] = 16'(randBits(16));
				end else if (listShape == 2'd1) begin
					w[15:0] = 16'd1 << 4'(randBits(4));   // Single register
				end else begin
					w[15:0] = 16'(randBits(16)) & 16'(randBits(16));   // Sparse list
				end
			end
		endcase
		return w;
	endfunction

	// Present one instruction and wait until its sequence is consumed
	task automatic runInstr(input instrWord word);
		uopList seq;
		int cycles;
		seq = expandInstr(word);
		foreach (seq[k]) begin
			expectQ.push_back(seq[k]);
		end
		instr <= word;
		stallIn <= drawStall();
		cycles = 0;
		while (expectQ.size() != 0) begin
			@(posedge clk);
			cycles++;
			if (cycles > 64) begin
				$display("Timeout: sequence of %h did not finish within 64 cycles", word);
				abortRun();
			end
			if (expectQ.size() != 0) begin
				stallIn <= drawStall();
			end
		end
	endtask

	// Outputs settle by the falling edge and the head is consumed only without stall
	initial begin
		expectedUop head;
		forever begin
			@(negedge clk);
			if (expectQ.size() != 0) begin
				head = expectQ[0];
				checkWord("uOpInstr", uOpInstr, head.word);
				checkBit("instrMux", instrMux, head.mux);
				checkBit("uOpStall", uOpStall, head.stall);
				checkBit("noFlagUpdate", noFlagUpdate, head.noFlag);
				checkBit("ldmStmForward", ldmStmForward, head.forward);
				checkBit("prevRsr", prevRsr, head.prevRsr);
				checkRz("regFileRz", regFileRz, head.rz);
				if (!stallIn) begin
					void'(expectQ.pop_front());
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		instr = '0;
		stallIn = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		runInstr(32'hE2811004);   // ADD r1, r1, #4
		runInstr(32'hE0810312);   // ADD r0, r1, r2, LSL r3
		runInstr(32'hE12FFF11);   // BX r1 looks like RSR but passes through
		runInstr(32'hEB000010);   // BL
		runInstr(32'hE8B00026);   // LDMIA r0!, {r1, r2, r5}
		runInstr(32'hE92D40F0);   // STMDB sp!, {r4-r7, lr}
		runInstr(32'hE8120008);   // LDMDA r2, {r3}
		runInstr(32'hE9930003);   // LDMIB r3, {r0, r1}
		for (int t = 0; t < 400; t++) begin
			runInstr(randomInstr(2'(randBits(2))));
		end
		$display("Testbench passed");
		$finish;
	end

endmodule
